//--- compile.f
rtl/i2s_pkg.sv
rtl/i2s_clock_gen.sv
rtl/i2s_deserializer.sv
rtl/i2s_channel_split.sv
rtl/peak_meter.sv
rtl/i2s_mic_rx.sv
tb/i2s_mic_model.sv
tb/tb_i2s_mic_rx.sv

//--- Makefile
# Verilator build for the I2S microphone receiver testbench.

VERILATOR ?= verilator
TOP       ?= tb_i2s_mic_rx
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := *** TEST PASSED ***

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_i2s_mic_rx.sv
module tb_i2s_mic_rx;

    localparam int sample_bits = 24;
    localparam int peak_window = 4;
    localparam int half_period = 50;
    localparam int drive_delay = 10;
    localparam int reset_cycles = 4;
    localparam int mag_w = i2s_pkg::max_sample_bits;
    localparam int half_bit_cycles = 16;
    localparam int bit_cycles = 32;
    localparam int slot_periods = 32;
    localparam int frame_cycles = 2048;
    localparam int max_positive = 2 ** (mag_w - 1) - 1;
    localparam int clock_frames = 3;
    localparam int known_pairs = 8;
    localparam int random_pairs = 20;
    localparam int split_pairs = 6;
    localparam int peak_windows = 3;
    localparam int test_frames = clock_frames + known_pairs + random_pairs + 1 + split_pairs +
                                 peak_windows * peak_window;
    localparam int sync_frames = 3 * 2 + peak_window + 1;   // Lining up before each stream.
    localparam int timeout_cycles = (test_frames + sync_frames + 4) * frame_cycles;

    logic                    audio_clk;
    logic                    rst_in;
    logic                    mic_data;
    logic                    i2s_clk;
    logic                    lrcl_clk;
    logic                    sample_valid;
    i2s_pkg::stereo_sample_t sample;
    logic                    peak_valid;
    i2s_pkg::peak_t          peak;
    i2s_pkg::stereo_sample_t tx_pairs[$];   // Pairs of the running test.
    int                      pass_count;
    int                      fail_count;

    i2s_mic_rx #(
        .sample_bits (sample_bits),
        .peak_window (peak_window)
    ) i_i2s_mic_rx (
        .audio_clk    (audio_clk),
        .rst_in       (rst_in),
        .mic_data     (mic_data),
        .i2s_clk      (i2s_clk),
        .lrcl_clk     (lrcl_clk),
        .sample_valid (sample_valid),
        .sample       (sample),
        .peak_valid   (peak_valid),
        .peak         (peak)
    );

    i2s_mic_model i_mic_model (
        .i2s_clk  (i2s_clk),
        .lrcl_clk (lrcl_clk),
        .mic_data (mic_data)
    );

    always #half_period audio_clk = ~audio_clk;

    initial begin
        #(timeout_cycles * 2 * half_period);
        $display("Timeout: run did not finish within %0d audio_clk cycles", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic i2s_pkg::stereo_sample_t make_pair(input logic [mag_w-1:0] left,
                                                          input logic [mag_w-1:0] right);
        i2s_pkg::stereo_sample_t pair;
        pair.left = left;
        pair.right = right;
        return pair;
    endfunction

    function automatic i2s_pkg::stereo_sample_t random_pair();
        logic [31:0] left_bits;
        logic [31:0] right_bits;
        left_bits = $urandom();
        right_bits = $urandom();
        return make_pair(left_bits[mag_w-1:0], right_bits[mag_w-1:0]);
    endfunction

    // Receiver keeps the top sample_bits, lower bits read as zero.
    function automatic i2s_pkg::stereo_sample_t expect_sample(input i2s_pkg::stereo_sample_t sent);
        logic [mag_w-1:0] mask;
        mask = '1;
        for (int b = 0; b < mag_w - sample_bits; b++) begin
            mask[b] = 1'b0;
        end
        return make_pair(sent.left & mask, sent.right & mask);
    endfunction

    function automatic logic [mag_w-1:0] expected_magnitude(input logic signed [mag_w-1:0] value);
        int full;
        full = value;
        if (full < 0) begin
            full = -full;
        end
        if (full > max_positive) begin
            full = max_positive;   // Most negative code has no positive twin.
        end
        return full[mag_w-1:0];
    endfunction

    task automatic compare_sample(input string test, input i2s_pkg::stereo_sample_t expected,
                                  input i2s_pkg::stereo_sample_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected left 0x%h right 0x%h, actual left 0x%h right 0x%h",
                     test, expected.left, expected.right, actual.left, actual.right);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_peak(input string test, input i2s_pkg::peak_t expected,
                                input i2s_pkg::peak_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected peaks 0x%h 0x%h, actual peaks 0x%h 0x%h", test,
                     expected.left_peak, expected.right_peak, actual.left_peak, actual.right_peak);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_count(input string test, input int expected, input int actual);
        if (actual != expected) begin
            $display("Fail %s: expected %0d, actual %0d", test, expected, actual);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic wait_sample(input string test, output i2s_pkg::stereo_sample_t got,
                               output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        got = '0;
        while (!ok && cycles < 2 * frame_cycles) begin
            @(posedge audio_clk);
            #drive_delay;
            cycles++;
            if (sample_valid) begin
                ok = 1'b1;
                got = sample;
            end
        end
        if (!ok) begin
            $display("%s: no sample strobe arrived within %0d cycles", test, cycles);
            fail_count++;
        end
    endtask

    task automatic wait_peak(input string test, output i2s_pkg::peak_t got, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        got = '0;
        while (!ok && cycles < (peak_window + 1) * frame_cycles) begin
            @(posedge audio_clk);
            #drive_delay;
            cycles++;
            if (peak_valid) begin
                ok = 1'b1;
                got = peak;
            end
        end
        if (!ok) begin
            $display("%s: no peak strobe arrived within %0d cycles", test, cycles);
            fail_count++;
        end
    endtask

    task automatic report_test(input string test, input int fails_before);
        $display("Test %s done: %0d failures", test, fail_count - fails_before);
    endtask

    // Pushes right after a strobe, so the model pops them on the next frames.
    task automatic run_stream(input string test, input bit check_tail);
        i2s_pkg::stereo_sample_t got;
        bit                      ok;
        wait_sample(test, got, ok);
        foreach (tx_pairs[i]) begin
            i_mic_model.push_pair(tx_pairs[i]);
        end
        for (int i = 0; i < tx_pairs.size() && ok; i++) begin
            wait_sample(test, got, ok);
            if (ok) begin
                compare_sample($sformatf("%s pair %0d", test, i), expect_sample(tx_pairs[i]), got);
            end
        end
        // Empty queue sends silence, so a repeated pair would show here.
        if (ok && check_tail) begin
            wait_sample(test, got, ok);
            if (ok) begin
                compare_sample($sformatf("%s tail", test), '0, got);
            end
        end
    endtask

    task automatic test_clock_shape();
        string name;
        int    fails_before;
        logic  prev_i2s;
        logic  prev_lrcl;
        int    i2s_run;
        int    lrcl_run;
        int    lrcl_runs;
        int    bad_edges;
        bit    first_i2s;
        bit    first_lrcl;
        name = "clock_shape";
        fails_before = fail_count;
        @(posedge audio_clk);
        #drive_delay;
        prev_i2s = i2s_clk;
        prev_lrcl = lrcl_clk;
        i2s_run = 1;
        lrcl_run = 1;
        lrcl_runs = 0;
        bad_edges = 0;
        first_i2s = 1'b1;
        first_lrcl = 1'b1;
        repeat (clock_frames * frame_cycles) begin
            @(posedge audio_clk);
            #drive_delay;
            if (i2s_clk != prev_i2s) begin
                if (!first_i2s) begin
                    compare_count({name, " i2s_clk half period"}, half_bit_cycles, i2s_run);
                end
                first_i2s = 1'b0;
                i2s_run = 1;
            end else begin
                i2s_run++;
            end
            if (lrcl_clk != prev_lrcl) begin
                if (i2s_clk) begin
                    bad_edges++;
                end
                if (!first_lrcl) begin
                    compare_count({name, " lrcl_clk slot"}, slot_periods * bit_cycles, lrcl_run);
                    lrcl_runs++;
                end
                first_lrcl = 1'b0;
                lrcl_run = 1;
            end else begin
                lrcl_run++;
            end
            prev_i2s = i2s_clk;
            prev_lrcl = lrcl_clk;
        end
        compare_count({name, " lrcl_clk edges with i2s_clk high"}, 0, bad_edges);
        if (lrcl_runs < 2) begin
            $display("%s: lrcl_clk did not complete a high and a low slot", name);
            fail_count++;
        end
        report_test(name, fails_before);
    endtask

    task automatic test_known_samples();
        int fails_before;
        fails_before = fail_count;
        tx_pairs.delete();
        tx_pairs.push_back(make_pair(24'h7fffff, 24'h800000));   // Full scale both ways.
        tx_pairs.push_back(make_pair(24'h800000, 24'h7fffff));
        tx_pairs.push_back(make_pair(24'h000000, 24'h000000));
        tx_pairs.push_back(make_pair(24'h000001, 24'hffffff));
        tx_pairs.push_back(make_pair(24'hffffff, 24'h000001));
        tx_pairs.push_back(make_pair(24'h555555, 24'haaaaaa));
        tx_pairs.push_back(make_pair(24'h123456, 24'hedcba9));
        tx_pairs.push_back(make_pair(24'h400000, 24'hc00000));
        run_stream("known_samples", 1'b0);
        report_test("known_samples", fails_before);
    endtask

    task automatic test_random_stream();
        int fails_before;
        fails_before = fail_count;
        tx_pairs.delete();
        repeat (random_pairs) begin
            tx_pairs.push_back(random_pair());
        end
        run_stream("random_stream", 1'b1);
        report_test("random_stream", fails_before);
    endtask

    task automatic test_channel_independence();
        int fails_before;
        fails_before = fail_count;
        tx_pairs.delete();
        tx_pairs.push_back(make_pair(24'h7fffff, 24'h000000));   // Left only.
        tx_pairs.push_back(make_pair(24'ha5a5a5, 24'h000000));
        tx_pairs.push_back(make_pair(24'h800001, 24'h000000));
        tx_pairs.push_back(make_pair(24'h000000, 24'h7fffff));   // Right only.
        tx_pairs.push_back(make_pair(24'h000000, 24'h5a5a5a));
        tx_pairs.push_back(make_pair(24'h000000, 24'h800001));
        run_stream("channel_split", 1'b0);
        report_test("channel_split", fails_before);
    endtask

    task automatic test_peak_meter();
        string                   name;
        int                      fails_before;
        i2s_pkg::stereo_sample_t got;
        i2s_pkg::peak_t          got_peak;
        i2s_pkg::peak_t          exp_peak;
        logic [mag_w-1:0]        mag;
        bit                      ok;
        name = "peak_meter";
        fails_before = fail_count;
        tx_pairs.delete();
        repeat (peak_window) begin
            tx_pairs.push_back(random_pair());
        end
        tx_pairs.push_back(make_pair(24'h800000, 24'h000010));
        tx_pairs.push_back(make_pair(24'h001000, 24'hffff00));
        tx_pairs.push_back(make_pair(24'h7ffff0, 24'h123456));
        tx_pairs.push_back(make_pair(24'hffffff, 24'h800001));
        tx_pairs.push_back(make_pair(24'h000005, 24'h800000));
        tx_pairs.push_back(make_pair(24'hfffffb, 24'h000003));
        tx_pairs.push_back(make_pair(24'h000002, 24'h7ffffe));
        tx_pairs.push_back(make_pair(24'h000000, 24'hfffff0));
        wait_peak(name, got_peak, ok);   // Window boundary.
        foreach (tx_pairs[i]) begin
            i_mic_model.push_pair(tx_pairs[i]);
        end
        for (int w = 0; w < peak_windows && ok; w++) begin
            exp_peak = '0;
            for (int k = 0; k < peak_window && ok; k++) begin
                wait_sample(name, got, ok);
                if (ok) begin
                    compare_sample($sformatf("%s pair %0d", name, w * peak_window + k),
                                   expect_sample(tx_pairs[w * peak_window + k]), got);
                end
                mag = expected_magnitude(tx_pairs[w * peak_window + k].left);
                exp_peak.left_peak = (mag > exp_peak.left_peak) ? mag : exp_peak.left_peak;
                mag = expected_magnitude(tx_pairs[w * peak_window + k].right);
                exp_peak.right_peak = (mag > exp_peak.right_peak) ? mag : exp_peak.right_peak;
            end
            if (ok) begin
                wait_peak(name, got_peak, ok);
                if (ok) begin
                    compare_peak($sformatf("%s window %0d", name, w), exp_peak, got_peak);
                end
            end
        end
        report_test(name, fails_before);
    endtask

    initial begin
        void'($urandom(83));
        audio_clk = 1'b0;
        rst_in = 1'b1;
        pass_count = 0;
        fail_count = 0;
        repeat (reset_cycles) @(posedge audio_clk);
        #drive_delay;
        rst_in = 1'b0;
        test_clock_shape();
        test_known_samples();
        test_random_stream();
        test_channel_independence();
        test_peak_meter();
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb/i2s_mic_model.sv
module i2s_mic_model (
    input  logic i2s_clk,
    input  logic lrcl_clk,
    output logic mic_data
);

    localparam int pad_bits = i2s_pkg::slot_bits - i2s_pkg::max_sample_bits;

    i2s_pkg::stereo_sample_t        pair_q[$];   // Pairs waiting for a frame.
    i2s_pkg::stereo_sample_t        cur_pair;
    logic [i2s_pkg::slot_bits-1:0]  shift_word;
    logic                           ws_last;
    logic                           left_due;
    logic                           right_due;

    initial begin
        mic_data = 1'b0;
        cur_pair = '0;
        shift_word = '0;
        ws_last = 1'b0;
        left_due = 1'b0;
        right_due = 1'b0;
    end

    task automatic push_pair(input i2s_pkg::stereo_sample_t pair);
        pair_q.push_back(pair);
    endtask

    // Word select is sampled mid-bit. A change makes the next bit an MSB.
    always @(posedge i2s_clk) begin
        if (lrcl_clk != ws_last) begin
            left_due = !lrcl_clk;
            right_due = lrcl_clk;
        end
        ws_last = lrcl_clk;
    end

    // Data moves on the falling edge, MSB first.
    always @(negedge i2s_clk) begin
        if (left_due) begin
            if (pair_q.size() > 0) begin
                cur_pair = pair_q.pop_front();
            end else begin
                cur_pair = '0;   // Silence when nothing is queued.
            end
            shift_word = {cur_pair.left, {pad_bits{1'b0}}};
            left_due = 1'b0;
        end else if (right_due) begin
            shift_word = {cur_pair.right, {pad_bits{1'b0}}};
            right_due = 1'b0;
        end else begin
            shift_word = shift_word << 1;
        end
        mic_data = shift_word[i2s_pkg::slot_bits-1];
    end

endmodule

//--- rtl/i2s_mic_rx.sv
module i2s_mic_rx #(
    parameter int sample_bits = 24,
    parameter int peak_window = 16
) (
    input  logic                    audio_clk,
    input  logic                    rst_in,
    input  logic                    mic_data,
    output logic                    i2s_clk,
    output logic                    lrcl_clk,
    output logic                    sample_valid,
    output i2s_pkg::stereo_sample_t sample,
    output logic                    peak_valid,
    output i2s_pkg::peak_t          peak
);

    logic                bit_strobe;
    logic                frame_start;
    logic                frame_valid;
    i2s_pkg::i2s_frame_t frame;

    i2s_clock_gen i_i2s_clock_gen (
        .audio_clk   (audio_clk),
        .rst_in      (rst_in),
        .i2s_clk     (i2s_clk),
        .lrcl_clk    (lrcl_clk),
        .bit_strobe  (bit_strobe),
        .frame_start (frame_start)
    );

    i2s_deserializer i_i2s_deserializer (
        .audio_clk   (audio_clk),
        .rst_in      (rst_in),
        .mic_data    (mic_data),
        .bit_strobe  (bit_strobe),
        .frame_start (frame_start),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    i2s_channel_split #(
        .sample_bits (sample_bits)
    ) i_i2s_channel_split (
        .audio_clk    (audio_clk),
        .rst_in       (rst_in),
        .frame_valid  (frame_valid),
        .frame        (frame),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    peak_meter #(
        .peak_window (peak_window)
    ) i_peak_meter (
        .audio_clk    (audio_clk),
        .rst_in       (rst_in),
        .sample_valid (sample_valid),
        .sample       (sample),
        .peak_valid   (peak_valid),
        .peak         (peak)
    );

endmodule

//--- rtl/peak_meter.sv
module peak_meter #(
    parameter int peak_window = 16
) (
    input  logic                    audio_clk,
    input  logic                    rst_in,
    input  logic                    sample_valid,
    input  i2s_pkg::stereo_sample_t sample,
    output logic                    peak_valid,
    output i2s_pkg::peak_t          peak
);

    localparam int mag_w = i2s_pkg::max_sample_bits;
    localparam int cnt_w = (peak_window > 1) ? $clog2(peak_window) : 1;
    localparam logic [mag_w-1:0] mag_max = {1'b0, {(mag_w - 1){1'b1}}};

    logic [mag_w-1:0] left_mag;
    logic [mag_w-1:0] right_mag;
    logic [mag_w-1:0] left_max;
    logic [mag_w-1:0] right_max;
    logic [mag_w-1:0] left_fold;
    logic [mag_w-1:0] right_fold;
    logic [cnt_w-1:0] pair_cnt;
    logic             window_done;

    // Absolute value. The most negative code has no positive twin.
    function automatic logic [mag_w-1:0] abs_sat(input logic signed [mag_w-1:0] value);
        if (!value[mag_w-1]) begin
            return value;
        end else if (value[mag_w-2:0] == '0) begin
            return mag_max;   // Saturate.
        end
        return ~value + 1'b1;
    endfunction

    assign left_mag = abs_sat(sample.left);
    assign right_mag = abs_sat(sample.right);

    // Running maxima including the current pair.
    assign left_fold = (left_mag > left_max) ? left_mag : left_max;
    assign right_fold = (right_mag > right_max) ? right_mag : right_max;

    assign window_done = sample_valid && (pair_cnt == cnt_w'(peak_window - 1));

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            peak_valid <= 1'b0;
            pair_cnt <= '0;
            left_max <= '0;
            right_max <= '0;
        end else begin
            peak_valid <= window_done;
            if (window_done) begin
                pair_cnt <= '0;   // Start a fresh window.
                left_max <= '0;
                right_max <= '0;
            end else if (sample_valid) begin
                pair_cnt <= pair_cnt + 1'b1;
                left_max <= left_fold;
                right_max <= right_fold;
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (window_done) begin
            peak.left_peak <= left_fold;
            peak.right_peak <= right_fold;
        end
    end

endmodule

//--- rtl/i2s_channel_split.sv
module i2s_channel_split #(
    parameter int sample_bits = 24
) (
    input  logic                    audio_clk,
    input  logic                    rst_in,
    input  logic                    frame_valid,
    input  i2s_pkg::i2s_frame_t     frame,
    output logic                    sample_valid,
    output i2s_pkg::stereo_sample_t sample
);

    localparam int slot_msb = i2s_pkg::slot_bits - 1;
    localparam int top_w = i2s_pkg::max_sample_bits;

    // Bits below the mic resolution are noise and get zeroed.
    localparam int trim_bits = top_w - sample_bits;
    localparam logic [top_w-1:0] keep_mask = {top_w{1'b1}} << trim_bits;

    logic [top_w-1:0] left_top;
    logic [top_w-1:0] right_top;
    logic [top_w-1:0] left_kept;
    logic [top_w-1:0] right_kept;

    // Sample MSB sits at the top of each slot.
    assign left_top = frame.left_slot[slot_msb -: top_w];
    assign right_top = frame.right_slot[slot_msb -: top_w];

    assign left_kept = left_top & keep_mask;
    assign right_kept = right_top & keep_mask;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= frame_valid;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (frame_valid) begin
            sample.left <= $signed(left_kept);
            sample.right <= $signed(right_kept);
        end
    end

endmodule

//--- rtl/i2s_deserializer.sv
module i2s_deserializer (
    input  logic                audio_clk,
    input  logic                rst_in,
    input  logic                mic_data,
    input  logic                bit_strobe,
    input  logic                frame_start,
    output logic                frame_valid,
    output i2s_pkg::i2s_frame_t frame
);

    localparam int cnt_w = $clog2(i2s_pkg::frame_bits);

    typedef enum logic {
        idle,
        accumulating
    } state_t;

    state_t                        state;
    logic [cnt_w-1:0]              bit_cnt;
    logic [i2s_pkg::frame_bits-1:0] shift_reg;
    logic [i2s_pkg::frame_bits-1:0] shift_next;
    logic                          last_bit;

    // New bit enters at the bottom, so the first bit ends up as the MSB.
    assign shift_next = {shift_reg[i2s_pkg::frame_bits-2:0], mic_data};

    // 64th capture of the frame.
    assign last_bit = (state == accumulating) && bit_strobe &&
                      (bit_cnt == cnt_w'(i2s_pkg::frame_bits - 1));

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state <= idle;
            bit_cnt <= '0;
            frame_valid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    frame_valid <= 1'b0;
                    if (frame_start) begin
                        state <= accumulating;
                        bit_cnt <= '0;
                    end
                end
                accumulating: begin
                    frame_valid <= last_bit;
                    if (frame_start && bit_cnt != '0) begin
                        bit_cnt <= '0;   // Re-anchor on a slipped frame.
                    end else if (bit_strobe) begin
                        bit_cnt <= bit_cnt + 1'b1;   // Wraps to 0 after bit 63.
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge audio_clk) begin
        if (bit_strobe) begin
            shift_reg <= shift_next;
        end
    end

    // Hand the whole frame out together with its strobe.
    always_ff @(posedge audio_clk) begin
        if (last_bit) begin
            frame <= i2s_pkg::i2s_frame_t'(shift_next);
        end
    end

endmodule

//--- rtl/i2s_clock_gen.sv
module i2s_clock_gen (
    input  logic audio_clk,
    input  logic rst_in,
    output logic i2s_clk,
    output logic lrcl_clk,
    output logic bit_strobe,
    output logic frame_start
);

    localparam int half_bit = 16;   // audio_clk cycles per half bit period.
    localparam int count_w = 11;    // 64 bit periods of 32 cycles.
    localparam int period_w = 6;

    logic [count_w-1:0]  frame_cnt;
    logic [count_w-1:0]  cnt_next;
    logic [period_w-1:0] bit_period;

    // Outputs are decoded from the next count so they line up with frame_cnt.
    assign cnt_next = frame_cnt + 1'b1;
    assign bit_period = cnt_next[count_w-1:5];

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            frame_cnt <= '0;
            i2s_clk <= 1'b0;
            lrcl_clk <= 1'b0;
            bit_strobe <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            frame_cnt <= cnt_next;
            i2s_clk <= cnt_next[4];   // Low for the first half of each bit.

            // Right slot runs one bit early, as I2S wants.
            lrcl_clk <= (bit_period >= period_w'(i2s_pkg::frame_bits / 2 - 1)) &&
                        (bit_period <= period_w'(i2s_pkg::frame_bits - 2));

            // Rising edge of i2s_clk.
            bit_strobe <= (cnt_next[4:0] == 5'(half_bit));
            frame_start <= (cnt_next == '0);
        end
    end

endmodule

//--- rtl/i2s_pkg.sv
package i2s_pkg;

    // Serial frame geometry.
    parameter int slot_bits = 32;        // Bits per channel slot.
    parameter int frame_bits = 64;       // Left slot then right slot.

    // Widest sample carried through the receiver.
    parameter int max_sample_bits = 24;

    // Raw frame as shifted in, left slot in the upper half.
    typedef struct packed {
        logic [slot_bits-1:0] left_slot;   // Left MSB arrives first.
        logic [slot_bits-1:0] right_slot;
    } i2s_frame_t;

    // Signed stereo pair, narrow samples left-aligned with zero fill.
    typedef struct packed {
        logic signed [max_sample_bits-1:0] left;
        logic signed [max_sample_bits-1:0] right;
    } stereo_sample_t;

    // Magnitude peaks over one window.
    typedef struct packed {
        logic [max_sample_bits-1:0] left_peak;
        logic [max_sample_bits-1:0] right_peak;
    } peak_t;

endpackage
